// ==== hw/pe_bus_pkg.sv ====
package pe_bus_pkg;

    ////////////////////////////////////////////////////////////
    // Core memory bus
    ////////////////////////////////////////////////////////////

    // One request per cycle while en is high, any we bit means write
    typedef struct packed {
        logic        en;
        logic [3:0]  we;
        logic [31:0] addr;
        logic [31:0] wdata;
    } pe_bus_req_t;

    typedef enum logic [1:0] {
        REGION_NONE,
        REGION_DMEM,
        REGION_RTC,
        REGION_PLIC
    } pe_region_e;

    // Upper address byte of each mapped region
    localparam logic [7:0] REGION_CODE_DMEM = 8'h01;
    localparam logic [7:0] REGION_CODE_RTC  = 8'h02;
    localparam logic [7:0] REGION_CODE_PLIC = 8'h04;

    // Address bits seen by memory and peripherals
    localparam int unsigned MEM_ADDR_W = 24;

    ////////////////////////////////////////////////////////////
    // Peripheral register offsets
    ////////////////////////////////////////////////////////////

    localparam logic [3:0] RTC_MTIME_LO = 4'h0;
    localparam logic [3:0] RTC_MTIME_HI = 4'h4;
    localparam logic [3:0] RTC_CMP_LO   = 4'h8;
    localparam logic [3:0] RTC_CMP_HI   = 4'hC;

    localparam logic [3:0] PLIC_ENABLE  = 4'h0;
    localparam logic [3:0] PLIC_PENDING = 4'h4;
    localparam logic [3:0] PLIC_CLAIM   = 4'h8;

endpackage

// ==== hw/brlite_pkg.sv ====
package brlite_pkg;

    // Mesh width, same byte width as one PE address coordinate
    localparam logic [7:0] N_PE_X = 8'd2;

    localparam int unsigned BR_SEQ_W      = 16;
    localparam int unsigned BR_PAYLOAD_W  = 32;
    localparam int unsigned BR_PRODUCER_W = 6;
    localparam int unsigned BR_KSVC_W     = 5;
    localparam int unsigned BR_ID_W       = 5;

    // Monitor services, index taken from the low ksvc bits
    localparam int unsigned BR_MON_NSVC  = 4;
    localparam int unsigned BR_MON_SVC_W = $clog2(BR_MON_NSVC);

    typedef enum logic [2:0] {
        BR_SVC_ALL = 3'h0,
        BR_SVC_TGT = 3'h1,
        BR_SVC_MON = 3'h2
    } br_svc_e;

    // Flit as carried by the broadcast network
    typedef struct packed {
        logic [BR_PAYLOAD_W-1:0]  payload;
        logic [BR_SEQ_W-1:0]      seq_source;
        logic [BR_SEQ_W-1:0]      seq_target;
        logic [BR_PRODUCER_W-1:0] producer;
        logic [BR_KSVC_W-1:0]     ksvc;
        logic [BR_ID_W-1:0]       id;
        br_svc_e                  service;
    } br_flit_t;

    // NI side flit, source and id are stamped by the local port
    typedef struct packed {
        logic [BR_PAYLOAD_W-1:0]  payload;
        logic [BR_SEQ_W-1:0]      seq_target;
        logic [BR_PRODUCER_W-1:0] producer;
        logic [BR_KSVC_W-1:0]     ksvc;
        br_svc_e                  service;
    } br_out_t;

    typedef struct packed {
        logic [BR_PAYLOAD_W-1:0]  payload;
        logic [BR_SEQ_W-1:0]      seq_source;
        logic [BR_PRODUCER_W-1:0] producer;
        logic [BR_MON_SVC_W-1:0]  msvc;
    } br_mon_t;

    typedef struct packed {
        logic [BR_PAYLOAD_W-1:0]  payload;
        logic [BR_SEQ_W-1:0]      seq_source;
        logic [BR_PRODUCER_W-1:0] producer;
        logic [BR_KSVC_W-1:0]     ksvc;
    } br_svc_t;

endpackage

// ==== hw/pe_addr_decode.sv ====
`timescale 1ns/1ps

module pe_addr_decode (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  pe_bus_pkg::pe_bus_req_t bus_req_i,
    input  logic [31:0]             rtc_rdata_i,
    input  logic [31:0]             plic_rdata_i,
    input  logic [31:0]             dmem_rdata_i,
    output logic                    rtc_sel_o,
    output logic                    plic_sel_o,
    output pe_bus_pkg::pe_bus_req_t dmem_req_o,
    output logic [31:0]             bus_rdata_o
);

    localparam int unsigned PAD_W = 32 - pe_bus_pkg::MEM_ADDR_W;

    pe_bus_pkg::pe_region_e region;
    pe_bus_pkg::pe_region_e region_q;

    // Region of the current request, none when idle
    always_comb begin
        region = pe_bus_pkg::REGION_NONE;
        if (bus_req_i.en) begin
            case (bus_req_i.addr[31:24])
                pe_bus_pkg::REGION_CODE_DMEM: region = pe_bus_pkg::REGION_DMEM;
                pe_bus_pkg::REGION_CODE_RTC:  region = pe_bus_pkg::REGION_RTC;
                pe_bus_pkg::REGION_CODE_PLIC: region = pe_bus_pkg::REGION_PLIC;
                default:                      region = pe_bus_pkg::REGION_NONE;
            endcase
        end
    end

    assign rtc_sel_o  = (region == pe_bus_pkg::REGION_RTC);
    assign plic_sel_o = (region == pe_bus_pkg::REGION_PLIC);

    // Data memory sees only its own accesses and the low address bits
    always_comb begin
        dmem_req_o      = bus_req_i;
        dmem_req_o.en   = (region == pe_bus_pkg::REGION_DMEM);
        dmem_req_o.addr = {{PAD_W{1'b0}}, bus_req_i.addr[pe_bus_pkg::MEM_ADDR_W-1:0]};
    end

    ////////////////////////////////////////////////////////////
    // Read return, one cycle after the request
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            region_q <= pe_bus_pkg::REGION_NONE;
        end else begin
            region_q <= region;
        end
    end

    // Unmapped reads fall through to the memory port
    always_comb begin
        case (region_q)
            pe_bus_pkg::REGION_RTC:  bus_rdata_o = rtc_rdata_i;
            pe_bus_pkg::REGION_PLIC: bus_rdata_o = plic_rdata_i;
            default:                 bus_rdata_o = dmem_rdata_i;
        endcase
    end

endmodule

// ==== hw/pe_rtc.sv ====
`timescale 1ns/1ps

module pe_rtc (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    sel_i,
    input  pe_bus_pkg::pe_bus_req_t bus_req_i,
    output logic [31:0]             rdata_o,
    output logic                    mti_o
);

    logic [63:0] mtime_q;
    logic [63:0] cmp_q;
    logic [31:0] rdata_q;
    logic [3:0]  offset;
    logic        wr;

    // Word aligned register offset
    assign offset = {bus_req_i.addr[3:2], 2'b00};
    assign wr     = sel_i && (|bus_req_i.we);

    ////////////////////////////////////////////////////////////
    // Tick counter and compare
    ////////////////////////////////////////////////////////////

    // Free running, writes to mtime have no effect
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtime_q <= '0;
        end else begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    // All ones keeps the interrupt quiet until software sets a deadline
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cmp_q <= '1;
        end else if (wr) begin
            for (int b = 0; b < 4; b++) begin
                if (bus_req_i.we[b]) begin
                    if (offset == pe_bus_pkg::RTC_CMP_LO) begin
                        cmp_q[8*b +: 8] <= bus_req_i.wdata[8*b +: 8];
                    end else if (offset == pe_bus_pkg::RTC_CMP_HI) begin
                        cmp_q[32 + 8*b +: 8] <= bus_req_i.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    assign mti_o = (mtime_q >= cmp_q);

    // Read half selected by offset
    always_ff @(posedge clk_i) begin
        if (sel_i) begin
            case (offset)
                pe_bus_pkg::RTC_MTIME_LO: rdata_q <= mtime_q[31:0];
                pe_bus_pkg::RTC_MTIME_HI: rdata_q <= mtime_q[63:32];
                pe_bus_pkg::RTC_CMP_LO:   rdata_q <= cmp_q[31:0];
                pe_bus_pkg::RTC_CMP_HI:   rdata_q <= cmp_q[63:32];
                default:                  rdata_q <= '0;
            endcase
        end
    end

    assign rdata_o = rdata_q;

endmodule

// ==== hw/pe_plic.sv ====
`timescale 1ns/1ps

module pe_plic (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    sel_i,
    input  pe_bus_pkg::pe_bus_req_t bus_req_i,
    input  logic                    ext_irq_i,
    input  logic                    iack_i,
    output logic [31:0]             rdata_o,
    output logic                    mei_o
);

    logic        enable_q;
    logic        pending_q;
    logic [31:0] rdata_q;
    logic [3:0]  offset;

    assign offset = {bus_req_i.addr[3:2], 2'b00};

    // Enable bit lives in byte 0
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            enable_q <= 1'b0;
        end else if (sel_i && bus_req_i.we[0] && (offset == pe_bus_pkg::PLIC_ENABLE)) begin
            enable_q <= bus_req_i.wdata[0];
        end
    end

    // Source high wins over an acknowledge in the same cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q <= 1'b0;
        end else if (ext_irq_i) begin
            pending_q <= 1'b1;
        end else if (iack_i) begin
            pending_q <= 1'b0;
        end
    end

    assign mei_o = pending_q & enable_q;

    // Claim returns the single source id, which is bit 0
    always_ff @(posedge clk_i) begin
        if (sel_i) begin
            case (offset)
                pe_bus_pkg::PLIC_ENABLE:  rdata_q <= {31'b0, enable_q};
                pe_bus_pkg::PLIC_PENDING: rdata_q <= {31'b0, pending_q};
                pe_bus_pkg::PLIC_CLAIM:   rdata_q <= {31'b0, pending_q};
                default:                  rdata_q <= '0;
            endcase
        end
    end

    assign rdata_o = rdata_q;

endmodule

// ==== hw/brlite_local_port.sv ====
`timescale 1ns/1ps

module brlite_local_port #(
    parameter logic [15:0] PE_ADDR = 16'h0000
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,

    input  logic                 br_rtr_req_i,
    input  brlite_pkg::br_flit_t br_rtr_flit_i,
    output logic                 br_rtr_ack_o,

    output logic                 br_mon_req_o,
    output brlite_pkg::br_mon_t  br_mon_flit_o,
    input  logic                 br_mon_ack_i,

    output logic                 br_svc_req_o,
    output brlite_pkg::br_svc_t  br_svc_flit_o,
    input  logic                 br_svc_ack_i,

    input  logic                 br_ni_req_i,
    input  brlite_pkg::br_out_t  br_ni_flit_i,
    output logic                 br_ni_ack_o,

    output logic                 br_rtr_req_o,
    output brlite_pkg::br_flit_t br_rtr_flit_o,
    input  logic                 br_rtr_ack_i
);

    // x in the high byte, y in the low byte, row major numbering
    localparam logic [15:0] SEQ_ADDR = {8'h00, PE_ADDR[7:0]} * {8'h00, brlite_pkg::N_PE_X}
                                     + {8'h00, PE_ADDR[15:8]};

    logic                           is_mon;
    logic [brlite_pkg::BR_ID_W-1:0] id_q;

    ////////////////////////////////////////////////////////////
    // Delivery from the router
    ////////////////////////////////////////////////////////////

    assign is_mon       = (br_rtr_flit_i.service == brlite_pkg::BR_SVC_MON);
    assign br_mon_req_o = br_rtr_req_i && is_mon;
    assign br_svc_req_o = br_rtr_req_i && !is_mon;
    assign br_rtr_ack_o = is_mon ? br_mon_ack_i : br_svc_ack_i;

    always_comb begin
        br_mon_flit_o.payload    = br_rtr_flit_i.payload;
        br_mon_flit_o.seq_source = br_rtr_flit_i.seq_source;
        br_mon_flit_o.producer   = br_rtr_flit_i.producer;
        br_mon_flit_o.msvc       = br_rtr_flit_i.ksvc[brlite_pkg::BR_MON_SVC_W-1:0];

        br_svc_flit_o.payload    = br_rtr_flit_i.payload;
        br_svc_flit_o.seq_source = br_rtr_flit_i.seq_source;
        br_svc_flit_o.producer   = br_rtr_flit_i.producer;
        br_svc_flit_o.ksvc       = br_rtr_flit_i.ksvc;
    end

    ////////////////////////////////////////////////////////////
    // Injection towards the router
    ////////////////////////////////////////////////////////////

    assign br_rtr_req_o = br_ni_req_i;
    assign br_ni_ack_o  = br_rtr_ack_i;

    always_comb begin
        br_rtr_flit_o.payload    = br_ni_flit_i.payload;
        br_rtr_flit_o.seq_source = SEQ_ADDR;
        br_rtr_flit_o.seq_target = br_ni_flit_i.seq_target;
        br_rtr_flit_o.producer   = br_ni_flit_i.producer;
        br_rtr_flit_o.ksvc       = br_ni_flit_i.ksvc;
        br_rtr_flit_o.id         = id_q;
        br_rtr_flit_o.service    = br_ni_flit_i.service;
    end

    // Message id, one step per accepted flit, wraps at 32
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            id_q <= '0;
        end else if (br_rtr_ack_i) begin
            id_q <= id_q + 1'b1;
        end
    end

endmodule

// ==== hw/pe_periph.sv ====
`timescale 1ns/1ps

module pe_periph #(
    parameter logic [15:0] PE_ADDR = 16'h0000
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,

    // Memory bus from the core
    input  pe_bus_pkg::pe_bus_req_t bus_req_i,
    output logic [31:0]             bus_rdata_o,
    output pe_bus_pkg::pe_bus_req_t dmem_req_o,
    input  logic [31:0]             dmem_rdata_i,

    // Interrupts
    input  logic                    ext_irq_i,
    input  logic                    iack_i,
    output logic                    mti_o,
    output logic                    mei_o,

    // Broadcast links
    input  logic                    br_rtr_req_i,
    input  brlite_pkg::br_flit_t    br_rtr_flit_i,
    output logic                    br_rtr_ack_o,
    output logic                    br_mon_req_o,
    output brlite_pkg::br_mon_t     br_mon_flit_o,
    input  logic                    br_mon_ack_i,
    output logic                    br_svc_req_o,
    output brlite_pkg::br_svc_t     br_svc_flit_o,
    input  logic                    br_svc_ack_i,
    input  logic                    br_ni_req_i,
    input  brlite_pkg::br_out_t     br_ni_flit_i,
    output logic                    br_ni_ack_o,
    output logic                    br_rtr_req_o,
    output brlite_pkg::br_flit_t    br_rtr_flit_o,
    input  logic                    br_rtr_ack_i
);

    logic        rtc_sel;
    logic        plic_sel;
    logic [31:0] rtc_rdata;
    logic [31:0] plic_rdata;

    ////////////////////////////////////////////////////////////
    // Memory map and peripherals
    ////////////////////////////////////////////////////////////

    pe_addr_decode u_decode (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .bus_req_i    (bus_req_i),
        .rtc_rdata_i  (rtc_rdata),
        .plic_rdata_i (plic_rdata),
        .dmem_rdata_i (dmem_rdata_i),
        .rtc_sel_o    (rtc_sel),
        .plic_sel_o   (plic_sel),
        .dmem_req_o   (dmem_req_o),
        .bus_rdata_o  (bus_rdata_o)
    );

    pe_rtc u_rtc (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .sel_i     (rtc_sel),
        .bus_req_i (bus_req_i),
        .rdata_o   (rtc_rdata),
        .mti_o     (mti_o)
    );

    pe_plic u_plic (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .sel_i     (plic_sel),
        .bus_req_i (bus_req_i),
        .ext_irq_i (ext_irq_i),
        .iack_i    (iack_i),
        .rdata_o   (plic_rdata),
        .mei_o     (mei_o)
    );

    ////////////////////////////////////////////////////////////
    // Broadcast local port
    ////////////////////////////////////////////////////////////

    brlite_local_port #(
        .PE_ADDR (PE_ADDR)
    ) u_br_local (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .br_rtr_req_i  (br_rtr_req_i),
        .br_rtr_flit_i (br_rtr_flit_i),
        .br_rtr_ack_o  (br_rtr_ack_o),
        .br_mon_req_o  (br_mon_req_o),
        .br_mon_flit_o (br_mon_flit_o),
        .br_mon_ack_i  (br_mon_ack_i),
        .br_svc_req_o  (br_svc_req_o),
        .br_svc_flit_o (br_svc_flit_o),
        .br_svc_ack_i  (br_svc_ack_i),
        .br_ni_req_i   (br_ni_req_i),
        .br_ni_flit_i  (br_ni_flit_i),
        .br_ni_ack_o   (br_ni_ack_o),
        .br_rtr_req_o  (br_rtr_req_o),
        .br_rtr_flit_o (br_rtr_flit_o),
        .br_rtr_ack_i  (br_rtr_ack_i)
    );

endmodule

// ==== bench/pe_periph_tb.sv ====
`timescale 1ns/1ps

module pe_periph_tb;

    // x 1 in the high byte, y 1 in the low byte, so y * 2 + x = 3
    localparam logic [15:0] PE_ADDR    = 16'h0101;
    localparam logic [15:0] EXP_SEQ    = 16'd3;
    // Whole sequence needs a few hundred cycles
    localparam int          MAX_CYCLES = 2000;

    logic                    clk_i;
    logic                    rst_ni;
    pe_bus_pkg::pe_bus_req_t bus_req_i;
    logic [31:0]             bus_rdata_o;
    pe_bus_pkg::pe_bus_req_t dmem_req_o;
    logic [31:0]             dmem_rdata_i;
    logic                    ext_irq_i;
    logic                    iack_i;
    logic                    mti_o;
    logic                    mei_o;
    logic                    br_rtr_req_i;
    brlite_pkg::br_flit_t    br_rtr_flit_i;
    logic                    br_rtr_ack_o;
    logic                    br_mon_req_o;
    brlite_pkg::br_mon_t     br_mon_flit_o;
    logic                    br_mon_ack_i;
    logic                    br_svc_req_o;
    brlite_pkg::br_svc_t     br_svc_flit_o;
    logic                    br_svc_ack_i;
    logic                    br_ni_req_i;
    brlite_pkg::br_out_t     br_ni_flit_i;
    logic                    br_ni_ack_o;
    logic                    br_rtr_req_o;
    brlite_pkg::br_flit_t    br_rtr_flit_o;
    logic                    br_rtr_ack_i;

    integer      seed;
    int          cycle_cnt = 0;
    int          rel_cycle;
    int          req_cycle;
    int          prev_cycle;
    int          target;
    int          ack_count;
    int          err_count = 0;
    int          check_count = 0;
    logic [31:0] r;
    logic [31:0] rd;
    logic [31:0] prev_time;
    logic        is_mon;

    pe_periph #(.PE_ADDR(PE_ADDR)) uut (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, test sequence did not complete", cycle_cnt);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Link level properties
    ////////////////////////////////////////////////////////////

    // Exactly one delivery path follows the router request
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (((br_mon_req_o || br_svc_req_o) == br_rtr_req_i) && !(br_mon_req_o && br_svc_req_o)))
    else begin
        err_count++;
        $display("[ERROR] t=%0t br_mon_req_o/br_svc_req_o expected one of %b got %b/%b",
                 $time, br_rtr_req_i, br_mon_req_o, br_svc_req_o);
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        ((br_rtr_req_o == br_ni_req_i) && (br_ni_ack_o == br_rtr_ack_i)))
    else begin
        err_count++;
        $display("[ERROR] t=%0t br_rtr_req_o/br_ni_ack_o expected %b/%b got %b/%b",
                 $time, br_ni_req_i, br_rtr_ack_i, br_rtr_req_o, br_ni_ack_o);
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_count++;
        assert (act === exp) else begin
            err_count++;
            $display("[ERROR] t=%0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #10;
    endtask

    function automatic logic [31:0] reg_addr(input logic [7:0] code, input logic [3:0] off);
        return {code, 20'h0, off};
    endfunction

    function automatic brlite_pkg::br_svc_e pick_service(input logic [1:0] sel);
        case (sel)
            2'd0:    return brlite_pkg::BR_SVC_ALL;
            2'd1:    return brlite_pkg::BR_SVC_TGT;
            default: return brlite_pkg::BR_SVC_MON;
        endcase
    endfunction

    task automatic bus_write(input logic [31:0] addr, input logic [3:0] we,
                             input logic [31:0] wdata);
        bus_req_i.en    = 1'b1;
        bus_req_i.we    = we;
        bus_req_i.addr  = addr;
        bus_req_i.wdata = wdata;
        @(negedge clk_i);
        check("dmem_req_o.en", 32'(addr[31:24] == 8'h01), 32'(dmem_req_o.en));
        if (addr[31:24] == 8'h01) begin
            check("dmem_req_o.we", 32'(we), 32'(dmem_req_o.we));
            check("dmem_req_o.wdata", wdata, dmem_req_o.wdata);
        end
        next_cycle();
        bus_req_i.en = 1'b0;
        bus_req_i.we = 4'h0;
    endtask

    // Memory word is driven in the return cycle and must come straight back
    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        logic [31:0] mem_word;
        logic        to_dmem;
        to_dmem         = (addr[31:24] == 8'h01);
        bus_req_i.en    = 1'b1;
        bus_req_i.we    = 4'h0;
        bus_req_i.addr  = addr;
        bus_req_i.wdata = '0;
        @(negedge clk_i);
        check("dmem_req_o.en", 32'(to_dmem), 32'(dmem_req_o.en));
        if (to_dmem) begin
            check("dmem_req_o.addr", {8'h00, addr[23:0]}, dmem_req_o.addr);
        end
        next_cycle();
        req_cycle    = cycle_cnt;
        bus_req_i.en = 1'b0;
        mem_word     = $random(seed);
        dmem_rdata_i = mem_word;
        @(negedge clk_i);
        data = bus_rdata_o;
        if (addr[31:24] != 8'h02 && addr[31:24] != 8'h04) begin
            check("bus_rdata_o", mem_word, bus_rdata_o);
        end
        next_cycle();
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        seed          = 32'hc164_9b5c;
        rst_ni        = 1'b0;
        bus_req_i     = '0;
        dmem_rdata_i  = '0;
        ext_irq_i     = 1'b0;
        iack_i        = 1'b0;
        br_rtr_req_i  = 1'b0;
        br_rtr_flit_i = '0;
        br_mon_ack_i  = 1'b0;
        br_svc_ack_i  = 1'b0;
        br_ni_req_i   = 1'b0;
        br_ni_flit_i  = '0;
        br_rtr_ack_i  = 1'b0;
        ack_count     = 0;
        repeat (5) @(posedge clk_i);
        #10;
        rst_ni    = 1'b1;
        rel_cycle = cycle_cnt;
        @(negedge clk_i);
        check("mti_o", 32'h0, 32'(mti_o));
        check("mei_o", 32'h0, 32'(mei_o));
        next_cycle();

        // Data memory and unmapped regions
        for (int i = 0; i < 8; i++) begin
            r = $random(seed);
            bus_read({8'h01, r[23:0]}, rd);
            bus_read({(i[0] ? 8'h08 : 8'h00), r[23:0]}, rd);
            bus_write({8'h01, r[23:0]}, 4'hF, $random(seed));
        end
        bus_req_i.addr = 32'h0100_0040;
        @(negedge clk_i);
        check("dmem_req_o.en", 32'h0, 32'(dmem_req_o.en));
        next_cycle();

        // RTC counts edges since reset release
        bus_read(reg_addr(8'h02, 4'h0), rd);
        check("mtime_lo", 32'(req_cycle - 1 - rel_cycle), rd);
        prev_time  = rd;
        prev_cycle = req_cycle;
        repeat (7) next_cycle();
        bus_read(reg_addr(8'h02, 4'h0), rd);
        check("mtime_lo delta", 32'(req_cycle - prev_cycle), rd - prev_time);
        bus_read(reg_addr(8'h02, 4'h4), rd);
        check("mtime_hi", 32'h0, rd);
        bus_write(reg_addr(8'h02, 4'h0), 4'hF, 32'hFFFF_FFFF);
        bus_read(reg_addr(8'h02, 4'h0), rd);
        check("mtime_lo after write", 32'(req_cycle - 1 - rel_cycle), rd);

        // Timer interrupt a little ahead of now
        target = cycle_cnt - rel_cycle + 30;
        bus_write(reg_addr(8'h02, 4'h8), 4'hF, 32'(target));
        bus_write(reg_addr(8'h02, 4'hC), 4'hF, 32'h0);
        repeat (40) begin
            @(negedge clk_i);
            check("mti_o", 32'((cycle_cnt - rel_cycle) >= target), 32'(mti_o));
            next_cycle();
        end
        bus_read(reg_addr(8'h02, 4'h8), rd);
        check("mtimecmp_lo", 32'(target), rd);
        bus_read(reg_addr(8'h02, 4'hC), rd);
        check("mtimecmp_hi", 32'h0, rd);
        bus_write(reg_addr(8'h02, 4'hC), 4'b0010, 32'h1234_AB56);
        bus_read(reg_addr(8'h02, 4'hC), rd);
        check("mtimecmp_hi strobe", 32'h0000_AB00, rd);
        check("mti_o", 32'h0, 32'(mti_o));

        // PLIC pending, enable and claim
        ext_irq_i = 1'b1;
        next_cycle();
        ext_irq_i = 1'b0;
        bus_read(reg_addr(8'h04, 4'h4), rd);
        check("plic pending", 32'h1, rd);
        check("mei_o", 32'h0, 32'(mei_o));
        bus_read(reg_addr(8'h04, 4'h8), rd);
        check("plic claim", 32'h1, rd);
        bus_write(reg_addr(8'h04, 4'h0), 4'h1, 32'h1);
        @(negedge clk_i);
        check("mei_o", 32'h1, 32'(mei_o));
        next_cycle();
        bus_read(reg_addr(8'h04, 4'h0), rd);
        check("plic enable", 32'h1, rd);
        // Source and acknowledge together keep the request pending
        ext_irq_i = 1'b1;
        iack_i    = 1'b1;
        next_cycle();
        ext_irq_i = 1'b0;
        @(negedge clk_i);
        check("mei_o", 32'h1, 32'(mei_o));
        next_cycle();
        iack_i = 1'b0;
        @(negedge clk_i);
        check("mei_o", 32'h0, 32'(mei_o));
        next_cycle();
        bus_read(reg_addr(8'h04, 4'h8), rd);
        check("plic claim", 32'h0, rd);

        // Broadcast delivery split
        for (int i = 0; i < 40; i++) begin
            r                        = $random(seed);
            br_rtr_flit_i.payload    = $random(seed);
            br_rtr_flit_i.seq_source = r[15:0];
            br_rtr_flit_i.seq_target = r[31:16];
            r                        = $random(seed);
            br_rtr_flit_i.producer   = r[5:0];
            br_rtr_flit_i.ksvc       = r[10:6];
            br_rtr_flit_i.id         = r[15:11];
            br_rtr_flit_i.service    = pick_service(r[25:24]);
            br_rtr_req_i             = r[20];
            br_mon_ack_i             = r[21];
            br_svc_ack_i             = r[22];
            is_mon = (br_rtr_flit_i.service == brlite_pkg::BR_SVC_MON);
            @(negedge clk_i);
            check("br_mon_req_o", 32'(br_rtr_req_i && is_mon), 32'(br_mon_req_o));
            check("br_svc_req_o", 32'(br_rtr_req_i && !is_mon), 32'(br_svc_req_o));
            check("br_rtr_ack_o", 32'(is_mon ? br_mon_ack_i : br_svc_ack_i), 32'(br_rtr_ack_o));
            if (is_mon) begin
                check("mon.payload", br_rtr_flit_i.payload, br_mon_flit_o.payload);
                check("mon.seq_source", 32'(br_rtr_flit_i.seq_source),
                      32'(br_mon_flit_o.seq_source));
                check("mon.producer", 32'(br_rtr_flit_i.producer), 32'(br_mon_flit_o.producer));
                check("mon.msvc", 32'(br_rtr_flit_i.ksvc[1:0]), 32'(br_mon_flit_o.msvc));
            end else begin
                check("svc.payload", br_rtr_flit_i.payload, br_svc_flit_o.payload);
                check("svc.seq_source", 32'(br_rtr_flit_i.seq_source),
                      32'(br_svc_flit_o.seq_source));
                check("svc.producer", 32'(br_rtr_flit_i.producer), 32'(br_svc_flit_o.producer));
                check("svc.ksvc", 32'(br_rtr_flit_i.ksvc), 32'(br_svc_flit_o.ksvc));
            end
            next_cycle();
        end
        br_rtr_req_i = 1'b0;

        // Injection, id must follow the acknowledge count across a wrap
        for (int i = 0; i < 48; i++) begin
            r                       = $random(seed);
            br_ni_flit_i.payload    = $random(seed);
            br_ni_flit_i.seq_target = r[15:0];
            br_ni_flit_i.producer   = r[21:16];
            br_ni_flit_i.ksvc       = r[26:22];
            br_ni_flit_i.service    = pick_service(r[28:27]);
            br_ni_req_i             = r[29] | r[30];
            br_rtr_ack_i            = (i % 4 != 3);
            @(negedge clk_i);
            check("rtr.seq_source", 32'(EXP_SEQ), 32'(br_rtr_flit_o.seq_source));
            check("rtr.payload", br_ni_flit_i.payload, br_rtr_flit_o.payload);
            check("rtr.seq_target", 32'(br_ni_flit_i.seq_target), 32'(br_rtr_flit_o.seq_target));
            check("rtr.producer", 32'(br_ni_flit_i.producer), 32'(br_rtr_flit_o.producer));
            check("rtr.ksvc", 32'(br_ni_flit_i.ksvc), 32'(br_rtr_flit_o.ksvc));
            check("rtr.service", 32'(br_ni_flit_i.service), 32'(br_rtr_flit_o.service));
            check("rtr.id", 32'(ack_count % 32), 32'(br_rtr_flit_o.id));
            next_cycle();
            if (br_rtr_ack_i) begin
                ack_count++;
            end
        end
        br_ni_req_i  = 1'b0;
        br_rtr_ack_i = 1'b0;

        $display("Checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
hw/pe_bus_pkg.sv
hw/brlite_pkg.sv
hw/pe_addr_decode.sv
hw/pe_rtc.sv
hw/pe_plic.sv
hw/brlite_local_port.sv
hw/pe_periph.sv
bench/pe_periph_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the pe_periph testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module pe_periph_tb -f files.f -o sim_pe_periph
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/sim_pe_periph)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
else
    exit 1
fi
